/* common/rtab_defines.svh */
// Replay table sizing
`ifndef RTAB_DEFINES_SVH
`define RTAB_DEFINES_SVH

// Number of table slots
`define RTAB_ENTRIES 8

// Cache-line address width
`define RTAB_NLINE_W 16

// Set index, taken from the low bits of the line address
`define RTAB_SET_W 4

// Byte offset inside a line
`define RTAB_OFFSET_W 6

// Request id carried through the table
`define RTAB_ID_W 8

`endif

/* common/rtab_req_pkg.sv */
// Replay table request types
`include "rtab_defines.svh"

package rtab_req_pkg;

    // Cache-line address
    typedef logic [`RTAB_NLINE_W-1:0] rtab_nline_t;

    // Slot index
    typedef logic [$clog2(`RTAB_ENTRIES)-1:0] rtab_ptr_t;

    // One bit per slot
    typedef logic [`RTAB_ENTRIES-1:0] rtab_slot_vec_t;

    // Request kept in a slot until it is replayed
    typedef struct packed {
        rtab_nline_t               nline;
        logic [`RTAB_OFFSET_W-1:0] offset;
        // High for a store, low for a load
        logic                      is_store;
        logic [`RTAB_ID_W-1:0]     id;
    } rtab_req_t;

endpackage

/* common/rtab_ctrl_pkg.sv */
// Replay table control types
package rtab_ctrl_pkg;

    // Reasons that keep an entry from being replayed
    typedef struct packed {
        logic mshr_hit;   // refill of the same line
        logic dir_set;    // refill of the same set
        logic miss_ready; // miss handler busy
    } rtab_deps_t;

    // Refill event seen by every slot
    typedef struct packed {
        logic                      valid;
        rtab_req_pkg::rtab_nline_t nline;
    } rtab_refill_t;

    // Slot state reported to the allocation and pop blocks
    typedef struct packed {
        logic                    valid;
        logic                    head;
        logic                    tail;
        logic                    ready;
        rtab_req_pkg::rtab_ptr_t next;
    } rtab_slot_stat_t;

    // Per-slot allocation command
    typedef struct packed {
        logic set_valid;
        logic set_head;
        logic clr_head;
        logic set_tail;
        logic clr_tail;
        logic link_next;
    } rtab_alloc_cmd_t;

    // List walk states
    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

endpackage

/* rtab/rtab_alloc.sv */
// Replay table allocation
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_alloc
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
(
    input  logic                                 check_i,
    input  rtab_nline_t                          check_nline_i,
    input  logic                                 alloc_i,
    input  logic                                 alloc_link_i,
    input  rtab_nline_t     [`RTAB_ENTRIES-1:0]  slot_nline_i,
    input  rtab_slot_stat_t [`RTAB_ENTRIES-1:0]  slot_stat_i,
    output logic                                 check_hit_o,
    output rtab_alloc_cmd_t [`RTAB_ENTRIES-1:0]  alloc_cmd_o,
    output rtab_ptr_t                            free_ptr_o
);

    rtab_slot_vec_t valid;
    rtab_slot_vec_t hit;
    rtab_slot_vec_t hit_tail;
    rtab_slot_vec_t free_1hot;
    logic           alloc;

    // Line compare against every live entry
    always_comb begin : line_check
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            valid[i]    = slot_stat_i[i].valid;
            hit[i]      = check_i & valid[i] & (slot_nline_i[i] == check_nline_i);
            hit_tail[i] = hit[i] & slot_stat_i[i].tail;
        end
    end

    assign check_hit_o = |hit;

    // Lowest free slot wins, so scan down and keep the last match
    always_comb begin : free_pick
        free_1hot  = '0;
        free_ptr_o = '0;
        for (int i = `RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_1hot  = rtab_slot_vec_t'(1) << i;
                free_ptr_o = rtab_ptr_t'(i);
            end
        end
    end

    assign alloc = alloc_i | alloc_link_i;

    // New entries are always the tail of their list
    // A linked entry is no head and takes over the tail from the matching slot
    always_comb begin : slot_cmds
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            alloc_cmd_o[i].set_valid = alloc & free_1hot[i];
            alloc_cmd_o[i].set_head  = alloc_i & free_1hot[i];
            alloc_cmd_o[i].clr_head  = alloc_link_i & free_1hot[i];
            alloc_cmd_o[i].set_tail  = alloc & free_1hot[i];
            alloc_cmd_o[i].clr_tail  = alloc_link_i & hit_tail[i];
            // Old tail points to the new entry
            alloc_cmd_o[i].link_next = alloc_link_i & hit_tail[i];
        end
    end

endmodule

/* rtab/rtab_slot.sv */
// Replay table entry
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_slot
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,
    input  rtab_alloc_cmd_t alloc_cmd_i,
    input  rtab_ptr_t       free_ptr_i,
    input  rtab_req_t       alloc_req_i,
    input  rtab_deps_t      alloc_deps_i,
    input  rtab_refill_t    refill_i,
    input  logic            miss_ready_i,
    input  logic            try_clr_i,
    input  logic            commit_i,
    input  logic            rback_i,
    input  rtab_deps_t      rback_deps_i,
    output rtab_slot_stat_t stat_o,
    output rtab_req_t       req_o
);

    logic       valid_q;
    logic       head_q;
    logic       tail_q;
    rtab_deps_t deps_q;
    rtab_deps_t deps_clr;
    rtab_ptr_t  next_q;
    rtab_req_t  req_q;
    logic       line_match;
    logic       set_match;

    // Refill compare on the stored line
    assign line_match = refill_i.valid & (refill_i.nline == req_q.nline);
    assign set_match  = refill_i.valid &
                        (refill_i.nline[`RTAB_SET_W-1:0] == req_q.nline[`RTAB_SET_W-1:0]);

    assign deps_clr.mshr_hit   = line_match;
    assign deps_clr.dir_set    = set_match;
    assign deps_clr.miss_ready = miss_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            valid_q <= 1'b0;
            head_q  <= 1'b0;
            tail_q  <= 1'b0;
            deps_q  <= '0;
            next_q  <= '0;
        end else begin
            if (alloc_cmd_i.set_valid) begin
                valid_q <= 1'b1;
            end else if (commit_i) begin
                valid_q <= 1'b0;
            end

            // Head drops while the entry is out for replay
            if (alloc_cmd_i.set_head || rback_i) begin
                head_q <= 1'b1;
            end else if (alloc_cmd_i.clr_head || try_clr_i || commit_i) begin
                head_q <= 1'b0;
            end

            if (alloc_cmd_i.set_tail) begin
                tail_q <= 1'b1;
            end else if (alloc_cmd_i.clr_tail) begin
                tail_q <= 1'b0;
            end

            // Fresh bits on allocation or rollback, else clear on events
            if (alloc_cmd_i.set_valid) begin
                deps_q <= alloc_deps_i;
            end else if (rback_i) begin
                deps_q <= rback_deps_i;
            end else begin
                deps_q <= deps_q & ~deps_clr;
            end

            if (alloc_cmd_i.link_next) begin
                next_q <= free_ptr_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin : payload_reg
        if (alloc_cmd_i.set_valid) begin
            req_q <= alloc_req_i;
        end
    end

    assign stat_o.valid = valid_q;
    assign stat_o.head  = head_q;
    assign stat_o.tail  = tail_q;
    // Replayable once no dependency is left
    assign stat_o.ready = valid_q & head_q & ~(|deps_q);
    assign stat_o.next  = next_q;
    assign req_o        = req_q;

endmodule

/* rtab/rtab_pop.sv */
// Replay table pop control
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_pop
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  rtab_slot_stat_t [`RTAB_ENTRIES-1:0]  stat_i,
    input  rtab_req_t       [`RTAB_ENTRIES-1:0]  slot_req_i,
    input  logic                                 pop_try_i,
    input  logic                                 pop_commit_i,
    input  logic                                 pop_rback_i,
    input  rtab_ptr_t                            pop_ptr_i,
    output logic                                 pop_valid_o,
    output rtab_req_t                            pop_req_o,
    output rtab_ptr_t                            pop_ptr_o,
    output rtab_slot_vec_t                       try_clr_o,
    output rtab_slot_vec_t                       commit_o,
    output rtab_slot_vec_t                       rback_o
);

    rtab_pop_state_e state_q;
    rtab_pop_state_e state_d;
    rtab_ptr_t       walk_q;
    rtab_ptr_t       walk_d;
    rtab_ptr_t       rr_q;
    rtab_ptr_t       gnt_ptr;
    rtab_slot_vec_t  ready;
    rtab_slot_vec_t  pop_sel;
    logic            pop_head;
    logic            cur_tail;
    rtab_ptr_t       cur_next;

    always_comb begin : ready_vec
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            ready[i] = stat_i[i].ready;
        end
    end

    // Round robin search starting just after the last granted head
    always_comb begin : rr_arb
        int idx;
        gnt_ptr = rr_q;
        for (int k = `RTAB_ENTRIES; k >= 1; k--) begin
            idx = (int'(rr_q) + k) % `RTAB_ENTRIES;
            if (ready[idx]) begin
                gnt_ptr = rtab_ptr_t'(idx);
            end
        end
    end

    // Offer a new head, or the next entry of the list being walked
    assign pop_valid_o = (state_q == POP_HEAD) ? |ready : 1'b1;
    assign pop_ptr_o   = (state_q == POP_HEAD) ? gnt_ptr : walk_q;
    assign cur_tail    = stat_i[pop_ptr_o].tail;
    assign cur_next    = stat_i[pop_ptr_o].next;

    // One-hot select, commit and rollback strobes
    always_comb begin : sel_decode
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            pop_sel[i]  = pop_valid_o & (pop_ptr_o == rtab_ptr_t'(i));
            commit_o[i] = pop_commit_i & (pop_ptr_i == rtab_ptr_t'(i));
            rback_o[i]  = pop_rback_i & (pop_ptr_i == rtab_ptr_t'(i));
        end
    end

    assign try_clr_o = pop_sel & {`RTAB_ENTRIES{pop_try_i}};

    always_comb begin : payload_mux
        pop_req_o = '0;
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            if (pop_sel[i]) begin
                pop_req_o = slot_req_i[i];
            end
        end
    end

    always_comb begin : walk_fsm
        state_d  = state_q;
        walk_d   = walk_q;
        pop_head = 1'b0;
        case (state_q)
            POP_HEAD: begin
                // A rollback of the last tail may still arrive here
                if (!pop_rback_i && pop_valid_o && pop_try_i) begin
                    pop_head = 1'b1;
                    if (!cur_tail) begin
                        state_d = POP_NEXT;
                        walk_d  = cur_next;
                    end
                end
            end
            POP_NEXT: begin
                // Previous entry resolves in this cycle
                if (pop_rback_i) begin
                    state_d = POP_HEAD;
                end else if (pop_try_i) begin
                    if (!cur_tail) begin
                        walk_d = cur_next;
                    end else begin
                        state_d = POP_HEAD;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            POP_NEXT_WAIT: begin
                // Hold the offer until taken
                if (pop_try_i) begin
                    if (!cur_tail) begin
                        state_d = POP_NEXT;
                        walk_d  = cur_next;
                    end else begin
                        state_d = POP_HEAD;
                    end
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_regs
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            walk_q  <= '0;
            rr_q    <= '0;
        end else begin
            state_q <= state_d;
            walk_q  <= walk_d;
            // Arbiter moves on only when a head is taken
            if (pop_head) begin
                rr_q <= gnt_ptr;
            end
        end
    end

endmodule

/* rtab/rtab_top.sv */
// Replay table top
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_top
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         check_i,
    input  rtab_nline_t  check_nline_i,
    output logic         check_hit_o,
    input  logic         alloc_i,
    input  logic         alloc_link_i,
    input  rtab_req_t    alloc_req_i,
    input  rtab_deps_t   alloc_deps_i,
    input  rtab_refill_t refill_i,
    input  logic         miss_ready_i,
    output logic         pop_valid_o,
    output rtab_req_t    pop_req_o,
    output rtab_ptr_t    pop_ptr_o,
    input  logic         pop_try_i,
    input  logic         pop_commit_i,
    input  logic         pop_rback_i,
    input  rtab_ptr_t    pop_ptr_i,
    input  rtab_deps_t   rback_deps_i,
    output logic         empty_o,
    output logic         full_o
);

    rtab_alloc_cmd_t [`RTAB_ENTRIES-1:0] alloc_cmd;
    rtab_slot_stat_t [`RTAB_ENTRIES-1:0] slot_stat;
    rtab_req_t       [`RTAB_ENTRIES-1:0] slot_req;
    rtab_nline_t     [`RTAB_ENTRIES-1:0] slot_nline;
    rtab_slot_vec_t                      slot_valid;
    rtab_slot_vec_t                      try_clr;
    rtab_slot_vec_t                      commit;
    rtab_slot_vec_t                      rback;
    rtab_ptr_t                           free_ptr;

    rtab_alloc u_alloc (
        .check_i       (check_i),
        .check_nline_i (check_nline_i),
        .alloc_i       (alloc_i),
        .alloc_link_i  (alloc_link_i),
        .slot_nline_i  (slot_nline),
        .slot_stat_i   (slot_stat),
        .check_hit_o   (check_hit_o),
        .alloc_cmd_o   (alloc_cmd),
        .free_ptr_o    (free_ptr)
    );

    for (genvar i = 0; i < `RTAB_ENTRIES; i++) begin : g_slot
        rtab_slot u_slot (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .alloc_cmd_i  (alloc_cmd[i]),
            .free_ptr_i   (free_ptr),
            .alloc_req_i  (alloc_req_i),
            .alloc_deps_i (alloc_deps_i),
            .refill_i     (refill_i),
            .miss_ready_i (miss_ready_i),
            .try_clr_i    (try_clr[i]),
            .commit_i     (commit[i]),
            .rback_i      (rback[i]),
            .rback_deps_i (rback_deps_i),
            .stat_o       (slot_stat[i]),
            .req_o        (slot_req[i])
        );

        // Line of each entry for the check compare
        assign slot_nline[i] = slot_req[i].nline;
        assign slot_valid[i] = slot_stat[i].valid;
    end

    rtab_pop u_pop (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .stat_i       (slot_stat),
        .slot_req_i   (slot_req),
        .pop_try_i    (pop_try_i),
        .pop_commit_i (pop_commit_i),
        .pop_rback_i  (pop_rback_i),
        .pop_ptr_i    (pop_ptr_i),
        .pop_valid_o  (pop_valid_o),
        .pop_req_o    (pop_req_o),
        .pop_ptr_o    (pop_ptr_o),
        .try_clr_o    (try_clr),
        .commit_o     (commit),
        .rback_o      (rback)
    );

    // Occupancy flags
    assign empty_o = ~(|slot_valid);
    assign full_o  = &slot_valid;

endmodule

/* bench/rtab_assertions.sv */
// Replay table checks
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_assertions
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
(
    input logic         clk_i,
    input logic         rst_ni,
    input logic         check_i,
    input rtab_nline_t  check_nline_i,
    input logic         check_hit_o,
    input logic         alloc_i,
    input logic         alloc_link_i,
    input rtab_req_t    alloc_req_i,
    input rtab_deps_t   alloc_deps_i,
    input rtab_refill_t refill_i,
    input logic         pop_valid_o,
    input rtab_req_t    pop_req_o,
    input rtab_ptr_t    pop_ptr_o,
    input logic         pop_try_i,
    input logic         pop_commit_i,
    input logic         pop_rback_i,
    input logic         empty_o,
    input logic         full_o
);

    localparam int IDS = 1 << `RTAB_ID_W;

    // Reference model with one record per request id
    logic [IDS-1:0]        out_q;
    logic [IDS-1:0]        mshr_q;
    logic [IDS-1:0]        rb_q;
    rtab_req_t             req_q  [IDS];
    rtab_ptr_t             slot_q [IDS];
    int                    seq_q  [IDS];
    // Slots taken in the model, filled lowest first
    rtab_slot_vec_t        used_q;
    rtab_ptr_t             model_free;
    int                    out_cnt;
    int                    alloc_seq;
    logic [`RTAB_ID_W-1:0] infl_id;
    logic                  model_hit;
    logic                  oldest_ok;
    logic                  failed = 1'b0;

    // Lowest free slot in the model, where the next allocation lands
    always_comb begin : model_slot
        logic found;
        found      = 1'b0;
        model_free = '0;
        for (int s = 0; s < `RTAB_ENTRIES; s++) begin
            if (!found && !used_q[s]) begin
                found      = 1'b1;
                model_free = rtab_ptr_t'(s);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : model
        if (!rst_ni) begin
            out_q     <= '0;
            mshr_q    <= '0;
            rb_q      <= '0;
            used_q    <= '0;
            out_cnt   <= 0;
            alloc_seq <= 0;
            infl_id   <= '0;
        end else begin
            // Line refill releases every request waiting on that line
            for (int i = 0; i < IDS; i++) begin
                if (refill_i.valid && (refill_i.nline == req_q[i].nline)) begin
                    mshr_q[i] <= 1'b0;
                end
            end
            if (pop_valid_o) begin
                rb_q[pop_req_o.id] <= 1'b0;
            end
            if (pop_valid_o && pop_try_i) begin
                infl_id <= pop_req_o.id;
            end
            if (pop_commit_i) begin
                out_q[infl_id]          <= 1'b0;
                used_q[slot_q[infl_id]] <= 1'b0;
            end
            if (pop_rback_i) begin
                rb_q[infl_id] <= 1'b1;
            end
            if (alloc_i || alloc_link_i) begin
                out_q[alloc_req_i.id]  <= 1'b1;
                mshr_q[alloc_req_i.id] <= alloc_deps_i.mshr_hit;
                req_q[alloc_req_i.id]  <= alloc_req_i;
                slot_q[alloc_req_i.id] <= model_free;
                used_q[model_free]     <= 1'b1;
                seq_q[alloc_req_i.id]  <= alloc_seq;
                alloc_seq              <= alloc_seq + 1;
            end
            out_cnt <= out_cnt + int'(alloc_i || alloc_link_i) - int'(pop_commit_i);
        end
    end

    // Line lookup, and whether the entry in flight is the oldest of its line
    always_comb begin : model_view
        model_hit = 1'b0;
        oldest_ok = 1'b1;
        for (int i = 0; i < IDS; i++) begin
            if (out_q[i] && (req_q[i].nline == check_nline_i)) begin
                model_hit = 1'b1;
            end
            if (out_q[i] && (i != int'(infl_id)) &&
                (req_q[i].nline == req_q[infl_id].nline) &&
                (seq_q[i] < seq_q[infl_id])) begin
                oldest_ok = 1'b0;
            end
        end
    end

    a_reset: assert property (@(posedge clk_i) $rose(rst_ni) |->
        empty_o && !pop_valid_o && !full_o)
        else begin
            $error("[ERROR] after reset empty_o=%h pop_valid_o=%h full_o=%h",
                   $sampled(empty_o), $sampled(pop_valid_o), $sampled(full_o));
            failed = 1'b1;
        end

    a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_i |-> (check_hit_o == model_hit))
        else begin
            $error("[ERROR] check_hit_o=%h expected %h for line %h",
                   $sampled(check_hit_o), $sampled(model_hit), $sampled(check_nline_i));
            failed = 1'b1;
        end

    // Lists keep allocation order per line
    a_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_commit_i |-> oldest_ok)
        else begin
            $error("[ERROR] commit of id %h overtakes an older request of line %h",
                   $sampled(infl_id), $sampled(req_q[infl_id].nline));
            failed = 1'b1;
        end

    a_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_valid_o |-> !mshr_q[pop_req_o.id])
        else begin
            $error("[ERROR] pop_req_o.id=%h offered before the refill of line %h",
                   $sampled(pop_req_o.id), $sampled(pop_req_o.nline));
            failed = 1'b1;
        end

    a_live: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_valid_o |-> out_q[pop_req_o.id])
        else begin
            $error("[ERROR] pop_req_o.id=%h offered but not outstanding",
                   $sampled(pop_req_o.id));
            failed = 1'b1;
        end

    // Offered entry sits in the slot it was given and carries its payload unchanged
    a_offer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_valid_o |-> (pop_ptr_o == slot_q[pop_req_o.id]) &&
                        (pop_req_o == req_q[pop_req_o.id]))
        else begin
            $error("[ERROR] pop_ptr_o=%h pop_req_o=%h expected %h %h",
                   $sampled(pop_ptr_o), $sampled(pop_req_o),
                   $sampled(slot_q[pop_req_o.id]), $sampled(req_q[pop_req_o.id]));
            failed = 1'b1;
        end

    // Every rolled-back request comes back before the table runs empty
    a_rback: assert property (@(posedge clk_i) disable iff (!rst_ni)
        empty_o |-> (rb_q == '0))
        else begin
            $error("[ERROR] empty_o=%h with rolled-back ids never offered again",
                   $sampled(empty_o));
            failed = 1'b1;
        end

    a_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (full_o == (out_cnt == `RTAB_ENTRIES)) && (empty_o == (out_cnt == 0)))
        else begin
            $error("[ERROR] full_o=%h empty_o=%h outstanding=%h",
                   $sampled(full_o), $sampled(empty_o), $sampled(out_cnt));
            failed = 1'b1;
        end

endmodule

/* bench/rtab_tb.sv */
// Replay table testbench
`timescale 1ns/1ps
`include "rtab_defines.svh"

module rtab_tb
    import rtab_req_pkg::*;
    import rtab_ctrl_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    localparam int RUN_CYCLES      = 1500;
    localparam int DRAIN_LIMIT     = 300;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + DRAIN_LIMIT + 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         check;
    rtab_nline_t  check_nline;
    logic         check_hit;
    logic         alloc;
    logic         alloc_link;
    rtab_req_t    alloc_req;
    rtab_deps_t   alloc_deps;
    rtab_refill_t refill;
    logic         miss_ready;
    logic         pop_valid;
    rtab_req_t    pop_req;
    rtab_ptr_t    pop_ptr;
    logic         pop_try;
    logic         pop_commit;
    logic         pop_rback;
    rtab_ptr_t    resolve_ptr;
    rtab_deps_t   rback_deps;
    logic         empty;
    logic         full;

    // Stimulus state
    logic [31:0]           lfsr = 32'h5761_483e;
    logic [`RTAB_ID_W-1:0] next_id = '0;
    logic                  resolving = 1'b0;
    rtab_ptr_t             tried_ptr = '0;
    // Four lines with two of them in the same set
    rtab_nline_t           pool [4] = '{16'h1a40, 16'h1a41, 16'h2b40, 16'h3c47};

    always #10 clk = ~clk;

    rtab_top DUT (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .check_i       (check),
        .check_nline_i (check_nline),
        .check_hit_o   (check_hit),
        .alloc_i       (alloc),
        .alloc_link_i  (alloc_link),
        .alloc_req_i   (alloc_req),
        .alloc_deps_i  (alloc_deps),
        .refill_i      (refill),
        .miss_ready_i  (miss_ready),
        .pop_valid_o   (pop_valid),
        .pop_req_o     (pop_req),
        .pop_ptr_o     (pop_ptr),
        .pop_try_i     (pop_try),
        .pop_commit_i  (pop_commit),
        .pop_rback_i   (pop_rback),
        .pop_ptr_i     (resolve_ptr),
        .rback_deps_i  (rback_deps),
        .empty_o       (empty),
        .full_o        (full)
    );

    bind rtab_top rtab_assertions u_checks (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check_i),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .alloc_i       (alloc_i),
        .alloc_link_i  (alloc_link_i),
        .alloc_req_i   (alloc_req_i),
        .alloc_deps_i  (alloc_deps_i),
        .refill_i      (refill_i),
        .pop_valid_o   (pop_valid_o),
        .pop_req_o     (pop_req_o),
        .pop_ptr_o     (pop_ptr_o),
        .pop_try_i     (pop_try_i),
        .pop_commit_i  (pop_commit_i),
        .pop_rback_i   (pop_rback_i),
        .empty_o       (empty_o),
        .full_o        (full_o)
    );

    task automatic fail_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic allocate();
        logic [31:0] r;
        draw_bits(2, r);
        check       = 1'b1;
        check_nline = pool[r[1:0]];
        // Line compare settles before new list or link is chosen
        #1;
        draw_bits(10, r);
        alloc_req.nline    = check_nline;
        alloc_req.offset   = r[5:0];
        alloc_req.is_store = r[6];
        alloc_req.id       = next_id;
        next_id            = next_id + 1'b1;
        alloc_deps         = rtab_deps_t'(r[9:7]);
        if (check_hit) begin
            // Linked entry follows its head and waits on no refill itself
            alloc_deps.mshr_hit = 1'b0;
            alloc_link          = 1'b1;
        end else begin
            alloc = 1'b1;
        end
    endtask

    task automatic drive_cycle(input logic drain, input int cyc);
        logic [31:0] r;
        check      = 1'b0;
        alloc      = 1'b0;
        alloc_link = 1'b0;
        pop_try    = 1'b0;
        pop_commit = 1'b0;
        pop_rback  = 1'b0;
        // Random refill of one pool line and miss handler pulse that drain forces on
        draw_bits(4, r);
        refill.valid = drain | r[0];
        refill.nline = drain ? pool[cyc % 4] : pool[r[2:1]];
        miss_ready   = drain | r[3];
        if (resolving) begin
            draw_bits(2, r);
            // Rollback about one time in four and never in drain
            pop_rback   = !drain && (r[1:0] == 2'b00);
            pop_commit  = !pop_rback;
            resolve_ptr = tried_ptr;
            resolving   = 1'b0;
        end else begin
            draw_bits(1, r);
            if (pop_valid && (drain || r[0])) begin
                pop_try   = 1'b1;
                tried_ptr = pop_ptr;
                resolving = 1'b1;
            end else if (!drain && !full) begin
                draw_bits(1, r);
                if (r[0]) begin
                    allocate();
                end
            end
        end
    endtask

    // Assertion failures end the run at the next falling edge
    always @(negedge clk) begin
        if (DUT.u_checks.failed) begin
            fail_run("a replay table assertion failed");
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the test finished");
    end

    initial begin : stimulus
        int waited;
        rst_n       = 1'b0;
        check       = 1'b0;
        check_nline = '0;
        alloc       = 1'b0;
        alloc_link  = 1'b0;
        alloc_req   = '0;
        alloc_deps  = '0;
        refill      = '0;
        miss_ready  = 1'b0;
        pop_try     = 1'b0;
        pop_commit  = 1'b0;
        pop_rback   = 1'b0;
        resolve_ptr = '0;
        rback_deps  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk);
            drive_cycle(1'b0, cyc);
        end
        // Drain with all dependencies cleared
        waited = 0;
        while (!(empty && !resolving) && (waited < DRAIN_LIMIT)) begin
            @(negedge clk);
            drive_cycle(1'b1, waited);
            waited++;
        end
        if (!empty) begin
            fail_run("table did not drain within the time limit");
        end
        @(negedge clk);
        if (DUT.u_checks.failed) begin
            fail_run("a replay table assertion failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+common
common/rtab_req_pkg.sv
common/rtab_ctrl_pkg.sv
rtab/rtab_alloc.sv
rtab/rtab_slot.sv
rtab/rtab_pop.sv
rtab/rtab_top.sv
bench/rtab_assertions.sv
bench/rtab_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rtab_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
